//--- Makefile
# Verilator build and run for the peripheral bus testbench

TOP := tb_periph_soc

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

//--- compile.f
source/soc_bus_pkg.sv
source/sync_ram.sv
source/apb_arbiter.sv
source/gpio_apb.sv
source/timer_apb.sv
source/shared_mem_apb.sv
source/periph_soc.sv
sim/soc_checker.sv
sim/tb_periph_soc.sv

//--- sim/soc_checker.sv
////////////////////////////////////////////////////////////////////////////
// bus monitor: read data, gpio pin and timer expiry checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module soc_checker
    import soc_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  apb_req_t             m_req    [num_masters],
    input  apb_rsp_t             m_rsp    [num_masters],
    input  logic [gpio_pins-1:0] gpio,
    input  logic                 timer_out,
    input  logic [1:0]           chk_kind [num_masters],
    input  logic [data_w-1:0]    chk_data [num_masters],
    output int                   checks,
    output int                   errors,
    output logic                 timer_seen
);

    logic                 gpio_pend;
    logic [gpio_pins-1:0] gpio_exp;

    function automatic logic is_gpio_write(input apb_req_t q);
        return q.pwrite && q.paddr[sel_lsb +: sel_w] == sel_w'(slv_gpio);
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            checks    = 0;
            errors    = 0;
            gpio_pend = 1'b0;
            gpio_exp  = '0;
        end else begin
            // pins show the write one edge after it completes
            if (gpio_pend) begin
                checks++;
                if (gpio !== gpio_exp) begin
                    errors++;
                    $display("MISMATCH %0t: gpio pins %h, expected %h", $time, gpio, gpio_exp);
                end
            end
            gpio_pend = 1'b0;
            for (int i = 0; i < num_masters; i++) begin
                if (m_req[i].psel && m_req[i].penable && m_rsp[i].pready) begin
                    if (is_gpio_write(m_req[i])) begin
                        gpio_pend = 1'b1;
                        gpio_exp  = m_req[i].pwdata[gpio_pins-1:0];
                    end
                    case (chk_kind[i])
                        // exact value
                        2'd1: begin
                            checks++;
                            if (m_rsp[i].prdata !== chk_data[i]) begin
                                errors++;
                                $display("MISMATCH %0t: master %0d address %h read %h, expected %h",
                                         $time, i, m_req[i].paddr, m_rsp[i].prdata, chk_data[i]);
                            end
                        end
                        // upper bound, running timer count
                        2'd2: begin
                            checks++;
                            if (m_rsp[i].prdata > chk_data[i]) begin
                                errors++;
                                $display("MISMATCH %0t: master %0d count %0d above load %0d",
                                         $time, i, m_rsp[i].prdata, chk_data[i]);
                            end
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timer_seen <= 1'b0;
        end else if (timer_out) begin
            timer_seen <= 1'b1;
        end
    end

endmodule

//--- sim/tb_periph_soc.sv
////////////////////////////////////////////////////////////////////////////
// testbench for periph_soc: clock, reset, stimulus table, master drivers,
// LFSR data source and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_periph_soc
    import soc_bus_pkg::*;
();

    localparam logic [1:0] ex_plain   = 2'b00;
    localparam logic [1:0] ex_load    = 2'b10;
    localparam logic [1:0] ex_store   = 2'b01;
    localparam logic [1:0] chk_none   = 2'd0;
    localparam logic [1:0] chk_eq     = 2'd1;
    localparam logic [1:0] chk_max    = 2'd2;
    localparam int         xfer_limit = 100;

    // one bus transfer with its expected response
    typedef struct packed {
        logic [3:0]        test;
        logic              master;
        logic              paired;
        logic [addr_w-1:0] addr;
        logic              write;
        logic [data_w-1:0] wdata;
        logic [1:0]        chk;
        logic [data_w-1:0] exp_data;
    } row_t;

    logic                 clk;
    logic                 arst_n;
    apb_req_t             m_req    [num_masters];
    apb_rsp_t             m_rsp    [num_masters];
    logic [gpio_pins-1:0] gpio;
    logic                 timer_out;
    logic [1:0]           chk_kind [num_masters];
    logic [data_w-1:0]    chk_data [num_masters];
    int                   checks;
    int                   errors;
    logic                 timer_seen;
    int                   hangs;
    logic [31:0]          lfsr;
    logic                 table_ready;
    row_t                 rows [$];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    periph_soc periph_soc_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .m_req     (m_req),
        .m_rsp     (m_rsp),
        .gpio      (gpio),
        .timer_out (timer_out)
    );

    soc_checker checker_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .m_req      (m_req),
        .m_rsp      (m_rsp),
        .gpio       (gpio),
        .timer_out  (timer_out),
        .chk_kind   (chk_kind),
        .chk_data   (chk_data),
        .checks     (checks),
        .errors     (errors),
        .timer_seen (timer_seen)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stimulus data
    ////////////////////////////////////////////////////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [data_w-1:0] rand_bits(input int n);
        logic [data_w-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[data_w-2:0], lfsr[31]};
        end
        return v;
    endfunction

    // core-id bits stay zero, the arbiter fills them in
    function automatic logic [addr_w-1:0] bus_addr(input logic [1:0] excl, input int slv,
                                                   input int off);
        return {excl, {core_id_w{1'b0}}, sel_w'(slv), sel_lsb'(off)};
    endfunction

    function automatic logic [addr_w-1:0] mem_at(input logic [1:0] excl, input int word);
        return bus_addr(excl, slv_mem, word);
    endfunction

    function automatic logic [addr_w-1:0] tmr_at(input logic [reg_off_w-1:0] off);
        return bus_addr(ex_plain, slv_timer, int'(off));
    endfunction

    task automatic put(input int test, input logic master, input logic paired,
                       input logic [addr_w-1:0] addr, input logic write,
                       input logic [data_w-1:0] wdata, input logic [1:0] chk,
                       input logic [data_w-1:0] exp_data);
        row_t x;
        x.test     = 4'(test);
        x.master   = master;
        x.paired   = paired;
        x.addr     = addr;
        x.write    = write;
        x.wdata    = wdata;
        x.chk      = chk;
        x.exp_data = exp_data;
        rows.push_back(x);
    endtask

    task automatic wr(input int test, input logic master, input logic [addr_w-1:0] addr,
                      input logic [data_w-1:0] wdata);
        put(test, master, 1'b0, addr, 1'b1, wdata, chk_none, '0);
    endtask

    task automatic rd(input int test, input logic master, input logic [addr_w-1:0] addr,
                      input logic [data_w-1:0] exp_data);
        put(test, master, 1'b0, addr, 1'b0, '0, chk_eq, exp_data);
    endtask

    task automatic build_table();
        logic [data_w-1:0] d [3];
        logic [data_w-1:0] ld;
        // gpio write and readback from the other master
        d[0] = rand_bits(16);
        d[1] = rand_bits(16);
        wr(1, 1'b0, bus_addr(ex_plain, slv_gpio, 0), d[0]);
        rd(1, 1'b1, bus_addr(ex_plain, slv_gpio, 0), data_w'(d[0][gpio_pins-1:0]));
        wr(1, 1'b1, bus_addr(ex_plain, slv_gpio, 0), d[1]);
        rd(1, 1'b0, bus_addr(ex_plain, slv_gpio, 0), data_w'(d[1][gpio_pins-1:0]));
        // timer, short load so expiry comes early
        ld = 16'd8 + rand_bits(4);
        wr(6, 1'b0, tmr_at(tmr_ctrl), '0);
        wr(6, 1'b0, tmr_at(tmr_load), ld);
        rd(6, 1'b1, tmr_at(tmr_load), ld);
        wr(6, 1'b0, tmr_at(tmr_pres), '0);
        wr(6, 1'b0, tmr_at(tmr_ctrl), data_w'(1 << ctrl_start));
        rd(6, 1'b1, tmr_at(tmr_ctrl), data_w'(1 << ctrl_start));
        put(6, 1'b0, 1'b0, tmr_at(tmr_load), 1'b0, '0, chk_max, ld);
        put(6, 1'b1, 1'b0, tmr_at(tmr_load), 1'b0, '0, chk_max, ld);
        put(6, 1'b0, 1'b0, tmr_at(tmr_load), 1'b0, '0, chk_max, ld);
        // plain memory, read back by the other master
        d[0] = rand_bits(16);
        d[1] = rand_bits(16);
        d[2] = rand_bits(16);
        wr(2, 1'b0, mem_at(ex_plain, 3), d[0]);
        wr(2, 1'b1, mem_at(ex_plain, 17), d[1]);
        wr(2, 1'b0, mem_at(ex_plain, 42), d[2]);
        rd(2, 1'b1, mem_at(ex_plain, 3), d[0]);
        rd(2, 1'b0, mem_at(ex_plain, 17), d[1]);
        rd(2, 1'b1, mem_at(ex_plain, 42), d[2]);
        // exclusive pair by one master, then a stale store
        d[0] = rand_bits(16);
        d[1] = rand_bits(16);
        d[2] = ~d[1];
        wr(3, 1'b0, mem_at(ex_plain, 5), d[0]);
        rd(3, 1'b0, mem_at(ex_load, 5), d[0]);
        put(3, 1'b0, 1'b0, mem_at(ex_store, 5), 1'b1, d[1], chk_eq, swex_ok);
        put(3, 1'b0, 1'b0, mem_at(ex_store, 5), 1'b1, d[2], chk_eq, swex_fail);
        rd(3, 1'b1, mem_at(ex_plain, 5), d[1]);
        // master 1 contends for a word locked by master 0
        d[0] = rand_bits(16);
        d[1] = rand_bits(16);
        d[2] = ~d[1];
        wr(4, 1'b0, mem_at(ex_plain, 9), d[0]);
        rd(4, 1'b0, mem_at(ex_load, 9), d[0]);
        rd(4, 1'b1, mem_at(ex_load, 9), d[0]);
        put(4, 1'b1, 1'b0, mem_at(ex_store, 9), 1'b1, d[1], chk_eq, swex_fail);
        put(4, 1'b0, 1'b0, mem_at(ex_store, 9), 1'b1, d[2], chk_eq, swex_ok);
        rd(4, 1'b1, mem_at(ex_plain, 9), d[2]);
        // both masters in the same cycle
        d[0] = rand_bits(16);
        d[1] = rand_bits(16);
        put(5, 1'b0, 1'b1, mem_at(ex_plain, 20), 1'b1, d[0], chk_none, '0);
        wr(5, 1'b1, mem_at(ex_plain, 21), d[1]);
        put(5, 1'b0, 1'b1, mem_at(ex_plain, 21), 1'b0, '0, chk_eq, d[1]);
        rd(5, 1'b1, mem_at(ex_plain, 20), d[0]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // master drivers
    ////////////////////////////////////////////////////////////////////////////

    function automatic apb_req_t to_req(input row_t x);
        apb_req_t q;
        q        = '0;
        q.paddr  = x.addr;
        q.pwrite = x.write;
        q.psel   = 1'b1;
        q.pwdata = x.wdata;
        return q;
    endfunction

    task automatic drive_m0(input row_t x);
        int n;
        n = 0;
        @(posedge clk);
        m_req[0]    <= to_req(x);
        chk_kind[0] <= x.chk;
        chk_data[0] <= x.exp_data;
        @(posedge clk);
        m_req[0].penable <= 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!m_rsp[0].pready && n < xfer_limit);
        m_req[0] <= '0;
        if (!m_rsp[0].pready) begin
            hangs++;
            $display("master 0 got no pready for address %h at %0t", x.addr, $time);
        end
    endtask

    task automatic drive_m1(input row_t x);
        int n;
        n = 0;
        @(posedge clk);
        m_req[1]    <= to_req(x);
        chk_kind[1] <= x.chk;
        chk_data[1] <= x.exp_data;
        @(posedge clk);
        m_req[1].penable <= 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!m_rsp[1].pready && n < xfer_limit);
        m_req[1] <= '0;
        if (!m_rsp[1].pready) begin
            hangs++;
            $display("master 1 got no pready for address %h at %0t", x.addr, $time);
        end
    endtask

    task automatic run_row(input row_t x);
        if (x.master) begin
            drive_m1(x);
        end else begin
            drive_m0(x);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int         r;
        int         err_mark;
        logic [3:0] cur_test;
        arst_n      = 1'b0;
        hangs       = 0;
        lfsr        = 32'h91127db8;
        table_ready = 1'b0;
        for (int i = 0; i < num_masters; i++) begin
            m_req[i]    = '0;
            chk_kind[i] = chk_none;
            chk_data[i] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        r        = 0;
        err_mark = 0;
        cur_test = rows[0].test;
        while (r < rows.size()) begin
            // paired row runs together with the row after it
            if (rows[r].paired) begin
                fork
                    run_row(rows[r]);
                    run_row(rows[r + 1]);
                join
                r += 2;
            end else begin
                run_row(rows[r]);
                r++;
            end
            if (r == rows.size() || rows[r].test != cur_test) begin
                repeat (2) @(negedge clk);
                $display("test %0d done at %0t, %0d errors", cur_test, $time,
                         errors + hangs - err_mark);
                err_mark = errors + hangs;
                if (r < rows.size()) begin
                    cur_test = rows[r].test;
                end
            end
        end
        if (!timer_seen) begin
            $display("timer_out never went high after the timer was started");
        end
        $display("%0d checks, %0d mismatches, %0d bus timeouts, timer expiry %s",
                 checks, errors, hangs, timer_seen ? "seen" : "missing");
        if (errors == 0 && hangs == 0 && timer_seen) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * 40 + 200) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- source/apb_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// two-master round-robin APB arbiter with core-id tagging and slave decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module apb_arbiter
    import soc_bus_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  apb_req_t m_req [num_masters],
    output apb_rsp_t m_rsp [num_masters],
    output apb_req_t s_req [num_slaves],
    input  apb_rsp_t s_rsp [num_slaves]
);

    logic [gnt_w-1:0]      grant_q;
    logic                  busy_q;
    logic [gnt_w-1:0]      pick;
    logic [gnt_w-1:0]      gnt_idx;
    apb_req_t              fwd;
    apb_rsp_t              fwd_rsp;
    logic [sel_w-1:0]      slv_idx;
    logic                  slv_hit;
    logic [num_slaves-1:0] s_psel;
    logic                  done;

    ////////////////////////////////////////////////////////////////////////////
    // master selection
    ////////////////////////////////////////////////////////////////////////////

    // search starts at the current grant, lowest distance wins
    always_comb begin
        int cand;
        cand = 0;
        pick = grant_q;
        for (int i = num_masters - 1; i >= 0; i--) begin
            cand = (int'(grant_q) + i) % num_masters;
            if (m_req[cand].psel) begin
                pick = gnt_w'(cand);
            end
        end
    end

    // owner is locked in while a transfer is open
    assign gnt_idx = busy_q ? grant_q : pick;

    always_comb begin
        fwd = m_req[gnt_idx];
        fwd.paddr[core_id_lsb +: core_id_w] = core_id_w'(gnt_idx);
        // first forwarded cycle is always a setup phase
        fwd.penable = busy_q & m_req[gnt_idx].penable;
    end

    ////////////////////////////////////////////////////////////////////////////
    // slave decode and response routing
    ////////////////////////////////////////////////////////////////////////////

    assign slv_idx = fwd.paddr[sel_lsb +: sel_w];
    assign slv_hit = int'(slv_idx) < num_slaves;

    always_comb begin
        for (int i = 0; i < num_slaves; i++) begin
            s_psel[i]     = fwd.psel & slv_hit & (slv_idx == sel_w'(i));
            s_req[i]      = fwd;
            s_req[i].psel = s_psel[i];
        end
    end

    // unmapped addresses finish in the access cycle with zero data
    always_comb begin
        fwd_rsp.prdata = '0;
        fwd_rsp.pready = fwd.psel & fwd.penable & ~slv_hit;
        for (int i = 0; i < num_slaves; i++) begin
            if (s_psel[i]) begin
                fwd_rsp = s_rsp[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_masters; i++) begin
            m_rsp[i] = (fwd.psel && gnt_idx == gnt_w'(i)) ? fwd_rsp : '0;
        end
    end

    assign done = fwd.psel & fwd_rsp.pready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_q <= '0;
            busy_q  <= 1'b0;
        end else if (done) begin
            busy_q  <= 1'b0;
            grant_q <= gnt_w'((int'(gnt_idx) + 1) % num_masters);
        end else if (fwd.psel) begin
            busy_q  <= 1'b1;
            grant_q <= gnt_idx;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_one_psel: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(s_psel));

    // granted master holds its address until the transfer ends
    a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (fwd.psel && !fwd_rsp.pready) |=> $stable(fwd.paddr));

endmodule

//--- source/gpio_apb.sv
////////////////////////////////////////////////////////////////////////////
// output port register slave
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module gpio_apb
    import soc_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  apb_req_t             req,
    output apb_rsp_t             rsp,
    output logic [gpio_pins-1:0] gpio
);

    logic [gpio_pins-1:0] gpio_q;
    logic                 access;

    assign access = req.psel & req.penable;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_q <= '0;
        end else if (access && req.pwrite) begin
            gpio_q <= req.pwdata[gpio_pins-1:0];
        end
    end

    // readback of the pin state, upper bits zero
    assign rsp.pready = access;
    assign rsp.prdata = access ? {{(data_w - gpio_pins){1'b0}}, gpio_q} : '0;

    assign gpio = gpio_q;

endmodule

//--- source/periph_soc.sv
////////////////////////////////////////////////////////////////////////////
// peripheral subsystem top, arbiter plus gpio, timer and shared memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module periph_soc
    import soc_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  apb_req_t             m_req [num_masters],
    output apb_rsp_t             m_rsp [num_masters],
    output logic [gpio_pins-1:0] gpio,
    output logic                 timer_out
);

    // shared slave side of the bus
    apb_req_t s_req [num_slaves];
    apb_rsp_t s_rsp [num_slaves];

    apb_arbiter arbiter_i (
        .clk    (clk),
        .arst_n (arst_n),
        .m_req  (m_req),
        .m_rsp  (m_rsp),
        .s_req  (s_req),
        .s_rsp  (s_rsp)
    );

    gpio_apb gpio_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (s_req[slv_gpio]),
        .rsp    (s_rsp[slv_gpio]),
        .gpio   (gpio)
    );

    timer_apb timer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (s_req[slv_timer]),
        .rsp       (s_rsp[slv_timer]),
        .timer_out (timer_out)
    );

    shared_mem_apb shared_mem_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (s_req[slv_mem]),
        .rsp    (s_rsp[slv_mem])
    );

endmodule

//--- source/shared_mem_apb.sv
////////////////////////////////////////////////////////////////////////////
// shared data memory slave with load/store-exclusive monitor
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module shared_mem_apb
    import soc_bus_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  apb_req_t req,
    output apb_rsp_t rsp
);

    logic [mem_addr_w-1:0] word_addr;
    logic [mem_addr_w-1:0] sweep_addr_q;
    logic                  sweep_q;
    logic                  wait_q;
    logic                  access;
    logic                  ready;
    logic                  lwex;
    logic                  swex;
    logic [core_id_w-1:0]  core_id;
    lock_t                 own_tag;
    lock_t                 lock_rd;
    lock_t                 lock_wd;
    logic [mem_addr_w-1:0] lock_addr;
    logic                  lock_we;
    logic                  is_locked;
    logic                  is_owner;
    logic                  swex_pass;
    logic [data_w-1:0]     data_rd;
    logic                  data_we;

    // address fields
    assign word_addr = req.paddr[mem_addr_w-1:0];
    assign swex      = req.paddr[swex_bit];
    assign lwex      = req.paddr[lwex_bit] & ~swex;
    assign core_id   = req.paddr[core_id_lsb +: core_id_w];
    assign own_tag   = {1'b0, core_id} + lock_t'(1);

    ////////////////////////////////////////////////////////////////////////////
    // lock flag clear after reset
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_q      <= 1'b1;
            sweep_addr_q <= '0;
        end else if (sweep_q) begin
            sweep_addr_q <= sweep_addr_q + 1'b1;
            if (sweep_addr_q == mem_addr_w'(mem_depth - 1)) begin
                sweep_q <= 1'b0;
            end
        end
    end

    // one wait state, flag and data are settled in the second access cycle
    assign access = req.psel & req.penable;
    assign ready  = access & wait_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access & ~wait_q & ~sweep_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // exclusive monitor
    ////////////////////////////////////////////////////////////////////////////

    assign is_locked = |lock_rd;
    assign is_owner  = is_locked & (lock_rd == own_tag);
    assign swex_pass = swex & is_owner;

    // plain writes always land, store-exclusive only for the owner
    assign data_we = ready & req.pwrite & (~swex | swex_pass);

    assign lock_addr = sweep_q ? sweep_addr_q : word_addr;
    assign lock_we   = sweep_q
                     | (ready & lwex & ~req.pwrite & ~is_locked)
                     | (ready & swex_pass);
    assign lock_wd   = (!sweep_q && lwex) ? own_tag : '0;

    sync_ram #(
        .word_t (logic [data_w-1:0])
    ) mem_data_i (
        .clk   (clk),
        .addr  (word_addr),
        .wdata (req.pwdata),
        .we    (data_we),
        .rdata (data_rd)
    );

    sync_ram #(
        .word_t (lock_t)
    ) mem_lock_i (
        .clk   (clk),
        .addr  (lock_addr),
        .wdata (lock_wd),
        .we    (lock_we),
        .rdata (lock_rd)
    );

    always_comb begin
        rsp.pready = ready;
        if (!ready) begin
            rsp.prdata = '0;
        end else if (swex) begin
            rsp.prdata = swex_pass ? swex_ok : swex_fail;
        end else begin
            rsp.prdata = data_rd;
        end
    end

    // owner match already stands in the first access cycle
    a_swex_locked: assert property (@(posedge clk) disable iff (!arst_n)
        (data_we && swex) |-> $past(lock_rd == own_tag));

endmodule

//--- source/soc_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bus widths, address map, register offsets and APB request/response types
////////////////////////////////////////////////////////////////////////////

package soc_bus_pkg;

    // bus geometry
    localparam int data_w      = 16;
    localparam int addr_w      = 20;
    localparam int num_masters = 2;
    localparam int gnt_w       = $clog2(num_masters);
    localparam int core_id_w   = 2;

    // address fields
    localparam int lwex_bit    = 19;
    localparam int swex_bit    = 18;
    localparam int core_id_lsb = 16;
    localparam int sel_lsb     = 12;
    localparam int sel_w       = 4;

    // slave map
    localparam int slv_gpio    = 0;
    localparam int slv_timer   = 1;
    localparam int slv_mem     = 2;
    localparam int num_slaves  = 3;

    // shared memory and gpio sizes
    localparam int mem_depth   = 64;
    localparam int mem_addr_w  = $clog2(mem_depth);
    localparam int gpio_pins   = 8;

    // timer registers
    localparam int reg_off_w   = 2;
    localparam logic [reg_off_w-1:0] tmr_load = 2'd0;
    localparam logic [reg_off_w-1:0] tmr_ctrl = 2'd1;
    localparam logic [reg_off_w-1:0] tmr_pres = 2'd2;
    localparam int ctrl_start  = 0;
    localparam int ctrl_reload = 1;

    // store-exclusive status words
    localparam logic [data_w-1:0] swex_ok   = 16'd0;
    localparam logic [data_w-1:0] swex_fail = 16'd1;

    // owner index plus one, zero is free
    typedef logic [core_id_w:0] lock_t;

    typedef struct packed {
        logic [addr_w-1:0] paddr;
        logic              pwrite;
        logic              psel;
        logic              penable;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

endpackage

//--- source/sync_ram.sv
////////////////////////////////////////////////////////////////////////////
// single-port RAM with registered read, word type set per instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sync_ram
    import soc_bus_pkg::*;
#(
    parameter type word_t = logic [data_w-1:0]
) (
    input  logic                  clk,
    input  logic [mem_addr_w-1:0] addr,
    input  word_t                 wdata,
    input  logic                  we,
    output word_t                 rdata
);

    word_t mem [mem_depth];

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- source/timer_apb.sv
////////////////////////////////////////////////////////////////////////////
// prescaled down-counting timer slave with expiry flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module timer_apb
    import soc_bus_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  apb_req_t req,
    output apb_rsp_t rsp,
    output logic     timer_out
);

    logic [data_w-1:0]    load_q;
    logic [data_w-1:0]    ctrl_q;
    logic [data_w-1:0]    pres_q;
    logic [data_w-1:0]    count_q;
    logic [data_w-1:0]    pres_cnt_q;
    logic [reg_off_w-1:0] offset;
    logic                 access;
    logic                 we;
    logic                 tick;

    assign offset = req.paddr[reg_off_w-1:0];
    assign access = req.psel & req.penable;
    assign we     = access & req.pwrite;

    // no wait states
    assign rsp.pready = access;

    always_comb begin
        rsp.prdata = '0;
        if (access) begin
            case (offset)
                tmr_load: rsp.prdata = count_q;
                tmr_ctrl: rsp.prdata = ctrl_q;
                default:  rsp.prdata = '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // prescaler
    ////////////////////////////////////////////////////////////////////////////

    // wraps from pres_q down to zero, one step strobe per wrap
    assign tick = (pres_cnt_q == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pres_cnt_q <= '0;
        end else if (tick) begin
            pres_cnt_q <= pres_q;
        end else begin
            pres_cnt_q <= pres_cnt_q - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers and counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q  <= '0;
            ctrl_q  <= '0;
            pres_q  <= '0;
            count_q <= '0;
        end else begin
            if (we && offset == tmr_ctrl) begin
                ctrl_q <= req.pwdata;
            end
            if (we && offset == tmr_pres) begin
                pres_q <= req.pwdata;
            end
            // a load write restarts the count
            if (we && offset == tmr_load) begin
                load_q  <= req.pwdata;
                count_q <= req.pwdata;
            end else if (ctrl_q[ctrl_start]) begin
                if (count_q == '0) begin
                    count_q <= load_q;
                end else if (tick) begin
                    count_q <= count_q - 1'b1;
                end
            end else if (ctrl_q[ctrl_reload]) begin
                count_q <= load_q;
            end
        end
    end

    assign timer_out = (count_q == '0) & ctrl_q[ctrl_start];

endmodule
